/* src/color_track_pkg.sv */
`default_nettype none

package color_track_pkg;

    localparam int HCOUNT_W = 11;   // up to 2047 columns
    localparam int VCOUNT_W = 10;
    localparam int H_ACTIVE = 1280;
    localparam int V_ACTIVE = 720;

    localparam int PIX565_W = 16;
    localparam int CHAN_W   = 8;
    localparam int THRESH_W = 4;    // switch nibble, lands in the top of an 8-bit bound

    localparam int SUM_W      = 32; // accumulators and divider datapath
    localparam int COUNT_W    = 21; // 1280*720 fits
    localparam int DIV_CYCLES = SUM_W;
    localparam int DIV_CNT_W  = $clog2(DIV_CYCLES);

    // rgb to ycrcb, coefficients scaled by 256
    localparam int COEF_W = 10;
    localparam int PROD_W = 18;     // widest sum is 66+129+25 times 255 plus rounding
    localparam logic signed [COEF_W-1:0] Y_R_COEF  = 10'sd66;
    localparam logic signed [COEF_W-1:0] Y_G_COEF  = 10'sd129;
    localparam logic signed [COEF_W-1:0] Y_B_COEF  = 10'sd25;
    localparam logic signed [COEF_W-1:0] CR_R_COEF = 10'sd112;
    localparam logic signed [COEF_W-1:0] CR_G_COEF = -10'sd94;
    localparam logic signed [COEF_W-1:0] CR_B_COEF = -10'sd18;
    localparam logic signed [COEF_W-1:0] CB_R_COEF = -10'sd38;
    localparam logic signed [COEF_W-1:0] CB_G_COEF = -10'sd74;
    localparam logic signed [COEF_W-1:0] CB_B_COEF = 10'sd112;
    localparam logic signed [PROD_W-1:0] ROUND_BIAS = 18'sd128; // half lsb before >>8
    localparam logic [CHAN_W-1:0] Y_OFFSET = 8'd16;
    localparam logic [CHAN_W-1:0] C_OFFSET = 8'd128;  // flips msb, signed to offset-binary

    localparam logic [1:0] CHAN_Y  = 2'd0;
    localparam logic [1:0] CHAN_CR = 2'd1;
    localparam logic [1:0] CHAN_CB = 2'd2;

    localparam logic [1:0] MODE_CAMERA  = 2'd0;
    localparam logic [1:0] MODE_CHANNEL = 2'd1;
    localparam logic [1:0] MODE_MASK    = 2'd2;
    localparam logic [1:0] MODE_OVERLAY = 2'd3;

endpackage

`default_nettype wire

/* src/pixel_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

// converted pixel, colour converter to thresholder
interface ycc_beat_if import color_track_pkg::*; ();
    logic                valid;
    logic                last;     // frame end
    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic [CHAN_W-1:0]   r, g, b;  // expanded 888
    logic [CHAN_W-1:0]   y;
    logic [CHAN_W-1:0]   cr, cb;   // offset-binary

    modport src (output valid, last, hcount, vcount, r, g, b, y, cr, cb);
    modport dst (input valid, last, hcount, vcount, r, g, b, y, cr, cb);
endinterface

// thresholded pixel, fans out to centroid and display
interface mask_beat_if import color_track_pkg::*; ();
    logic                valid;
    logic                last;
    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic [CHAN_W-1:0]   r, g, b;
    logic [CHAN_W-1:0]   y;
    logic [CHAN_W-1:0]   chan;     // whichever of y/cr/cb was picked
    logic                mask;

    modport src (output valid, last, hcount, vcount, r, g, b, y, chan, mask);
    modport dst (input valid, last, hcount, vcount, r, g, b, y, chan, mask);
endinterface

`default_nettype wire

/* src/color_convert.sv */
`timescale 1ns/1ps
`default_nettype none

module color_convert import color_track_pkg::*; (
    input  wire                 clk_pixel,
    input  wire                 recent_reset,
    input  wire                 pixel_valid_i,
    input  wire                 frame_end_i,
    input  wire [HCOUNT_W-1:0]  hcount_i,
    input  wire [VCOUNT_W-1:0]  vcount_i,
    input  wire [PIX565_W-1:0]  pixel_i,
    ycc_beat_if.src             ycc_o
);

    // stage 1, 565 widened to 888
    logic                s1_valid, s1_last;
    logic [HCOUNT_W-1:0] s1_hcount;
    logic [VCOUNT_W-1:0] s1_vcount;
    logic [CHAN_W-1:0]   s1_r, s1_g, s1_b;

    // stage 2, weighted sums (still scaled by 256)
    logic                s2_valid, s2_last;
    logic [HCOUNT_W-1:0] s2_hcount;
    logic [VCOUNT_W-1:0] s2_vcount;
    logic [CHAN_W-1:0]   s2_r, s2_g, s2_b;
    logic signed [PROD_W-1:0] y_sum, cr_sum, cb_sum;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            ycc_o.valid <= 1'b0;
        end else begin
            s1_valid    <= pixel_valid_i;
            s2_valid    <= s1_valid;
            ycc_o.valid <= s2_valid;
        end
    end

    always_ff @(posedge clk_pixel) begin
        s1_last   <= frame_end_i;
        s1_hcount <= hcount_i;
        s1_vcount <= vcount_i;
        s1_r      <= {pixel_i[15:11], 3'b000};  // low bits zero, not replicated
        s1_g      <= {pixel_i[10:5], 2'b00};
        s1_b      <= {pixel_i[4:0], 3'b000};
    end

    always_ff @(posedge clk_pixel) begin
        s2_last   <= s1_last;
        s2_hcount <= s1_hcount;
        s2_vcount <= s1_vcount;
        s2_r      <= s1_r;
        s2_g      <= s1_g;
        s2_b      <= s1_b;
        // colours zero-extended so the multiply stays signed
        y_sum  <= Y_R_COEF * $signed({1'b0, s1_r}) + Y_G_COEF * $signed({1'b0, s1_g})
                + Y_B_COEF * $signed({1'b0, s1_b}) + ROUND_BIAS;
        cr_sum <= CR_R_COEF * $signed({1'b0, s1_r}) + CR_G_COEF * $signed({1'b0, s1_g})
                + CR_B_COEF * $signed({1'b0, s1_b}) + ROUND_BIAS;
        cb_sum <= CB_R_COEF * $signed({1'b0, s1_r}) + CB_G_COEF * $signed({1'b0, s1_g})
                + CB_B_COEF * $signed({1'b0, s1_b}) + ROUND_BIAS;
    end

    // stage 3
    // bits [15:8] are the low byte of sum >>> 8, then offset, wrap to 8 bits
    always_ff @(posedge clk_pixel) begin
        ycc_o.last   <= s2_last;
        ycc_o.hcount <= s2_hcount;
        ycc_o.vcount <= s2_vcount;
        ycc_o.r      <= s2_r;
        ycc_o.g      <= s2_g;
        ycc_o.b      <= s2_b;
        ycc_o.y      <= y_sum[15:8] + Y_OFFSET;
        ycc_o.cr     <= cr_sum[15:8] + C_OFFSET;   // same as msb inversion
        ycc_o.cb     <= cb_sum[15:8] + C_OFFSET;
    end

endmodule

`default_nettype wire

/* src/channel_threshold.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_threshold import color_track_pkg::*; (
    input  wire                 clk_pixel,
    input  wire                 recent_reset,
    ycc_beat_if.dst             ycc_i,
    input  wire [1:0]           channel_sel_i,
    input  wire [THRESH_W-1:0]  lower_i,
    input  wire [THRESH_W-1:0]  upper_i,
    mask_beat_if.src            beat_o
);

    logic [CHAN_W-1:0] sel_chan;
    logic [CHAN_W-1:0] lower_bound, upper_bound;

    // switch nibble is the top half of the bound
    assign lower_bound = {lower_i, {(CHAN_W-THRESH_W){1'b0}}};
    assign upper_bound = {upper_i, {(CHAN_W-THRESH_W){1'b0}}};

    always_comb begin
        case (channel_sel_i)
            CHAN_Y:  sel_chan = ycc_i.y;
            CHAN_CR: sel_chan = ycc_i.cr;
            CHAN_CB: sel_chan = ycc_i.cb;
            default: sel_chan = ycc_i.y;   // spare code falls back to luma
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            beat_o.valid <= 1'b0;
        end else begin
            beat_o.valid <= ycc_i.valid;
        end
    end

    always_ff @(posedge clk_pixel) begin
        beat_o.last   <= ycc_i.last;
        beat_o.hcount <= ycc_i.hcount;
        beat_o.vcount <= ycc_i.vcount;
        beat_o.r      <= ycc_i.r;
        beat_o.g      <= ycc_i.g;
        beat_o.b      <= ycc_i.b;
        beat_o.y      <= ycc_i.y;
        beat_o.chan   <= sel_chan;
        beat_o.mask   <= (lower_bound <= sel_chan) && (sel_chan <= upper_bound); // inclusive
    end

endmodule

`default_nettype wire

/* src/serial_divider.sv */
`timescale 1ns/1ps
`default_nettype none

// restoring divider, first quotient bit is resolved on the start edge
module serial_divider import color_track_pkg::*; (
    input  wire              clk_pixel,
    input  wire              recent_reset,
    input  wire              start_i,
    input  wire [SUM_W-1:0]  dividend_i,
    input  wire [SUM_W-1:0]  divisor_i,
    output logic [SUM_W-1:0] quotient_o,
    output logic             done_o
);

    logic                 busy;
    logic [DIV_CNT_W-1:0] bits_left;   // iterations still to go after this one
    logic [SUM_W-1:0]     rem_q, quo_q, div_q;
    logic [SUM_W-1:0]     rem_in, quo_in, div_in;
    logic [SUM_W:0]       shifted, diff;
    logic [SUM_W-1:0]     rem_next, quo_next;

    always_comb begin
        rem_in  = start_i ? '0 : rem_q;
        quo_in  = start_i ? dividend_i : quo_q;  // dividend shifts out msb first
        div_in  = start_i ? divisor_i : div_q;
        shifted = {rem_in, quo_in[SUM_W-1]};
        diff    = shifted - {1'b0, div_in};
        if (!diff[SUM_W]) begin  // no borrow, subtraction fits
            rem_next = diff[SUM_W-1:0];
            quo_next = {quo_in[SUM_W-2:0], 1'b1};
        end else begin
            rem_next = shifted[SUM_W-1:0];
            quo_next = {quo_in[SUM_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            busy      <= 1'b0;
            done_o    <= 1'b0;
            bits_left <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy      <= 1'b1;
                bits_left <= DIV_CNT_W'(DIV_CYCLES - 1);
            end else if (busy) begin
                bits_left <= bits_left - 1'b1;
                if (bits_left == 1) begin  // final bit lands this edge
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (start_i || busy) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
        end
        if (start_i) begin
            div_q <= divisor_i;
        end
    end

    assign quotient_o = quo_q;   // meaningful while done_o is high

endmodule

`default_nettype wire

/* src/center_of_mass.sv */
`timescale 1ns/1ps
`default_nettype none

module center_of_mass import color_track_pkg::*; (
    input  wire                 clk_pixel,
    input  wire                 recent_reset,
    mask_beat_if.dst            beat_i,
    output logic [HCOUNT_W-1:0] x_com_o,
    output logic [VCOUNT_W-1:0] y_com_o,
    output logic                com_valid_o
);

    logic               hit;
    logic [SUM_W-1:0]   x_sum, y_sum, x_next, y_next;
    logic [COUNT_W-1:0] count, count_next;

    // snapshot of the finished frame, held for the dividers
    logic [SUM_W-1:0]   x_num, y_num, den;
    logic               div_start;
    logic [SUM_W-1:0]   x_quot, y_quot;
    logic               x_done, y_done;

    assign hit        = beat_i.valid && beat_i.mask;
    assign x_next     = x_sum + (hit ? SUM_W'(beat_i.hcount) : '0);
    assign y_next     = y_sum + (hit ? SUM_W'(beat_i.vcount) : '0);
    assign count_next = count + (hit ? COUNT_W'(1) : '0);

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            x_sum     <= '0;
            y_sum     <= '0;
            count     <= '0;
            div_start <= 1'b0;
        end else begin
            div_start <= 1'b0;
            if (beat_i.valid && beat_i.last) begin
                x_sum     <= '0;   // fresh frame starts next beat
                y_sum     <= '0;
                count     <= '0;
                div_start <= (count_next != '0);  // empty frame, keep old centre
            end else if (beat_i.valid) begin
                x_sum <= x_next;
                y_sum <= y_next;
                count <= count_next;
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (beat_i.valid && beat_i.last) begin
            x_num <= x_next;   // frame-end pixel counts too
            y_num <= y_next;
            den   <= SUM_W'(count_next);
        end
    end

    serial_divider u_x_div (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .start_i      (div_start),
        .dividend_i   (x_num),
        .divisor_i    (den),
        .quotient_o   (x_quot),
        .done_o       (x_done)
    );

    serial_divider u_y_div (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .start_i      (div_start),
        .dividend_i   (y_num),
        .divisor_i    (den),
        .quotient_o   (y_quot),
        .done_o       (y_done)
    );

    // both run in lockstep, but wait on the pair anyway
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            x_com_o     <= '0;
            y_com_o     <= '0;
            com_valid_o <= 1'b0;
        end else begin
            com_valid_o <= x_done && y_done;
            if (x_done && y_done) begin
                x_com_o <= x_quot[HCOUNT_W-1:0];  // mean of on-screen coords, always fits
                y_com_o <= y_quot[VCOUNT_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* src/video_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module video_mux import color_track_pkg::*; (
    input  wire                 clk_pixel,
    input  wire                 recent_reset,
    mask_beat_if.dst            beat_i,
    input  wire [1:0]           display_sel_i,
    input  wire                 crosshair_en_i,
    input  wire [HCOUNT_W-1:0]  x_com_i,
    input  wire [VCOUNT_W-1:0]  y_com_i,
    output logic [CHAN_W-1:0]   red_o,
    output logic [CHAN_W-1:0]   green_o,
    output logic [CHAN_W-1:0]   blue_o,
    output logic                valid_o,
    output logic                last_o
);

    logic [3*CHAN_W-1:0] bg_rgb, pix_rgb;
    logic                on_cross;

    always_comb begin
        case (display_sel_i)
            MODE_CAMERA:  bg_rgb = {beat_i.r, beat_i.g, beat_i.b};
            MODE_CHANNEL: bg_rgb = {3{beat_i.chan}};           // gray
            MODE_MASK:    bg_rgb = {3*CHAN_W{beat_i.mask}};    // white or black
            MODE_OVERLAY: bg_rgb = beat_i.mask ? 24'hFF00FF : {3{beat_i.chan}};
            default:      bg_rgb = {beat_i.r, beat_i.g, beat_i.b};
        endcase
    end

    // crosshair wins over every mode
    assign on_cross = crosshair_en_i && ((beat_i.hcount == x_com_i) || (beat_i.vcount == y_com_i));
    assign pix_rgb  = on_cross ? '1 : bg_rgb;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            valid_o <= 1'b0;
            last_o  <= 1'b0;
        end else begin
            valid_o <= beat_i.valid;
            last_o  <= beat_i.valid && beat_i.last;
        end
    end

    always_ff @(posedge clk_pixel) begin
        {red_o, green_o, blue_o} <= pix_rgb;
    end

endmodule

`default_nettype wire

/* src/color_track_top.sv */
`timescale 1ns/1ps
`default_nettype none

module color_track_top import color_track_pkg::*; (
    input  wire                 clk_pixel,
    input  wire                 recent_reset,
    input  wire                 pixel_valid_i,
    input  wire                 frame_end_i,      // on the last pixel of a frame
    input  wire [HCOUNT_W-1:0]  hcount_i,
    input  wire [VCOUNT_W-1:0]  vcount_i,
    input  wire [PIX565_W-1:0]  pixel_i,
    input  wire [1:0]           channel_sel_i,
    input  wire [THRESH_W-1:0]  lower_i,
    input  wire [THRESH_W-1:0]  upper_i,
    input  wire [1:0]           display_sel_i,
    input  wire                 crosshair_en_i,
    output logic [CHAN_W-1:0]   red_o,
    output logic [CHAN_W-1:0]   green_o,
    output logic [CHAN_W-1:0]   blue_o,
    output logic                valid_o,          // 5 clocks after pixel_valid_i
    output logic                last_o,
    output logic [HCOUNT_W-1:0] x_com_o,
    output logic [VCOUNT_W-1:0] y_com_o,
    output logic                com_valid_o
);

    ycc_beat_if  u_ycc_beat ();
    mask_beat_if u_mask_beat ();

    // 3 cycles
    color_convert u_color_convert (
        .clk_pixel     (clk_pixel),
        .recent_reset  (recent_reset),
        .pixel_valid_i (pixel_valid_i),
        .frame_end_i   (frame_end_i),
        .hcount_i      (hcount_i),
        .vcount_i      (vcount_i),
        .pixel_i       (pixel_i),
        .ycc_o         (u_ycc_beat)
    );

    // 1 cycle
    channel_threshold u_channel_threshold (
        .clk_pixel     (clk_pixel),
        .recent_reset  (recent_reset),
        .ycc_i         (u_ycc_beat),
        .channel_sel_i (channel_sel_i),
        .lower_i       (lower_i),
        .upper_i       (upper_i),
        .beat_o        (u_mask_beat)
    );

    // runs beside the display path, result lands well after frame end
    center_of_mass u_center_of_mass (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .beat_i       (u_mask_beat),
        .x_com_o      (x_com_o),
        .y_com_o      (y_com_o),
        .com_valid_o  (com_valid_o)
    );

    // 1 cycle
    video_mux u_video_mux (
        .clk_pixel      (clk_pixel),
        .recent_reset   (recent_reset),
        .beat_i         (u_mask_beat),
        .display_sel_i  (display_sel_i),
        .crosshair_en_i (crosshair_en_i),
        .x_com_i        (x_com_o),   // last finished centre
        .y_com_i        (y_com_o),
        .red_o          (red_o),
        .green_o        (green_o),
        .blue_o         (blue_o),
        .valid_o        (valid_o),
        .last_o         (last_o)
    );

endmodule

`default_nettype wire

/* verification/color_track_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module color_track_checker import color_track_pkg::*; (
    input wire                 clk_pixel,
    input wire                 recent_reset,
    input wire                 pixel_valid_i,
    input wire                 frame_end_i,
    input wire [HCOUNT_W-1:0]  hcount_i,
    input wire [VCOUNT_W-1:0]  vcount_i,
    input wire [PIX565_W-1:0]  pixel_i,
    input wire [12:0]          settings_i,  // mode, chan, lower, upper, crosshair
    input wire [CHAN_W-1:0]    red_i, green_i, blue_i,
    input wire                 valid_i, last_i, com_valid_i,
    input wire [HCOUNT_W-1:0]  x_com_i,
    input wire [VCOUNT_W-1:0]  y_com_i,
    output int                 err_count_o,
    output int                 pending_o
);

    logic [24:0] pix_q[$];   // {last, r, g, b}
    logic [20:0] com_q[$];   // {x, y}
    int sx, sy, cnt, mx, my;

    // integer conversion straight from the formula, wrap to a byte
    function automatic logic [7:0] ycc(int kr, int kg, int kb, int off, int r, int g, int b);
        int t;
        t = off + ((kr * r + kg * g + kb * b + 128) >>> 8);
        return t[7:0];
    endfunction

    initial err_count_o = 0;

    always @(posedge clk_pixel) begin : watch
        int r, g, b, ch;
        logic m;
        logic [23:0] rgb;
        logic [24:0] exp_pix;
        logic [20:0] exp_com;
        if (recent_reset) begin
            sx = 0;
            sy = 0;
            cnt = 0;
            mx = 0;
            my = 0;
            pix_q.delete();
            com_q.delete();
        end else begin
            if (pixel_valid_i) begin
                r = {pixel_i[15:11], 3'b000};
                g = {pixel_i[10:5], 2'b00};
                b = {pixel_i[4:0], 3'b000};
                case (settings_i[10:9])
                    2'd1:    ch = ycc(112, -94, -18, 128, r, g, b);
                    2'd2:    ch = ycc(-38, -74, 112, 128, r, g, b);
                    default: ch = ycc(66, 129, 25, 16, r, g, b);
                endcase
                m = (settings_i[8:5] * 16 <= ch) && (ch <= settings_i[4:1] * 16);
                case (settings_i[12:11])
                    2'd0: rgb = {r[7:0], g[7:0], b[7:0]};
                    2'd1: rgb = {3{ch[7:0]}};
                    2'd2: rgb = m ? 24'hFFFFFF : 24'h000000;
                    default: rgb = m ? 24'hFF00FF : {3{ch[7:0]}};
                endcase
                // crosshair uses the centre known before this pixel
                if (settings_i[0] && (hcount_i == mx || vcount_i == my)) rgb = 24'hFFFFFF;
                pix_q.push_back({frame_end_i, rgb});
                if (m) begin
                    sx += hcount_i;
                    sy += vcount_i;
                    cnt++;
                end
                if (frame_end_i) begin
                    if (cnt > 0) begin
                        mx = sx / cnt;
                        my = sy / cnt;
                        com_q.push_back({mx[10:0], my[9:0]});
                    end
                    sx = 0;
                    sy = 0;
                    cnt = 0;
                end
            end
            if (valid_i) begin
                if (pix_q.size() == 0) begin
                    $display("ERROR %0t: output beat with no pixel expected", $time);
                    err_count_o++;
                end else begin
                    exp_pix = pix_q.pop_front();
                    if ({last_i, red_i, green_i, blue_i} !== exp_pix) begin
                        $display("ERROR %0t: pixel expected %h got %h", $time, exp_pix,
                                 {last_i, red_i, green_i, blue_i});
                        err_count_o++;
                    end
                end
            end
            if (com_valid_i) begin
                if (com_q.size() == 0) begin
                    $display("ERROR %0t: centroid pulse with no frame pending", $time);
                    err_count_o++;
                end else begin
                    exp_com = com_q.pop_front();
                    if ({x_com_i, y_com_i} !== exp_com) begin
                        $display("ERROR %0t: centroid expected (%0d,%0d) got (%0d,%0d)", $time,
                                 exp_com[20:10], exp_com[9:0], x_com_i, y_com_i);
                        err_count_o++;
                    end
                end
            end
        end
        pending_o = pix_q.size() + com_q.size();
    end

endmodule

`default_nettype wire

/* verification/color_track_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module color_track_properties import color_track_pkg::*; (
    input wire                clk_pixel,
    input wire                recent_reset,
    input wire                pixel_valid_i,
    input wire                valid_o,
    input wire                com_valid_o,
    input wire [HCOUNT_W-1:0] x_com_o,
    input wire [VCOUNT_W-1:0] y_com_o
);

    int fail_count;   // failed assertions so far

    initial fail_count = 0;

    // fixed 5-clock video pipeline, both directions
    a_latency_fwd: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        pixel_valid_i |-> ##5 valid_o)
        else begin
            fail_count++;
            $error("valid_o missing 5 cycles after input");
        end
    a_latency_bwd: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        valid_o |-> $past(pixel_valid_i, 5))
        else begin
            fail_count++;
            $error("valid_o without matching input");
        end

    a_single_pulse: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        com_valid_o |=> !com_valid_o)
        else begin
            fail_count++;
            $error("com_valid_o high two cycles");
        end

    // centre only moves together with the pulse
    a_com_stable: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        !($stable(x_com_o) && $stable(y_com_o)) |-> com_valid_o)
        else begin
            fail_count++;
            $error("centre changed without com_valid_o");
        end

    a_reset_idle: assert property (@(posedge clk_pixel)
        $past(recent_reset) |-> (!valid_o && !com_valid_o && x_com_o == 0 && y_com_o == 0))
        else begin
            fail_count++;
            $error("outputs not idle after reset");
        end

endmodule

bind color_track_top color_track_properties u_color_track_properties (.*);

`default_nettype wire

/* verification/color_track_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module color_track_tb import color_track_pkg::*; ();

    logic clk_pixel, recent_reset, pixel_valid, frame_end;
    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic [PIX565_W-1:0] pixel;
    logic [12:0] settings;
    wire  [CHAN_W-1:0] red, green, blue;
    wire  valid, last, com_valid;
    wire  [HCOUNT_W-1:0] x_com;
    wire  [VCOUNT_W-1:0] y_com;
    int   chk_errors, pending, tb_err, last_errs, tests_run, tests_failed, n_entries;
    integer seed;
    // stimulus table
    logic [HCOUNT_W-1:0] e_h[128];
    logic [VCOUNT_W-1:0] e_v[128];
    logic [PIX565_W-1:0] e_pix[128];
    logic e_last[128];
    logic [12:0] e_set[128];
    int e_idle[128], e_test[128];
    string test_name[7] = '{"", "camera", "channel", "mask/overlay", "centroid", "crosshair",
                            "reset"};

    color_track_top u_color_track_top (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset), .pixel_valid_i(pixel_valid),
        .frame_end_i(frame_end), .hcount_i(hcount), .vcount_i(vcount), .pixel_i(pixel),
        .channel_sel_i(settings[10:9]), .lower_i(settings[8:5]), .upper_i(settings[4:1]),
        .display_sel_i(settings[12:11]), .crosshair_en_i(settings[0]),
        .red_o(red), .green_o(green), .blue_o(blue), .valid_o(valid), .last_o(last),
        .x_com_o(x_com), .y_com_o(y_com), .com_valid_o(com_valid));

    color_track_checker u_checker (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset), .pixel_valid_i(pixel_valid),
        .frame_end_i(frame_end), .hcount_i(hcount), .vcount_i(vcount), .pixel_i(pixel),
        .settings_i(settings), .red_i(red), .green_i(green), .blue_i(blue), .valid_i(valid),
        .last_i(last), .com_valid_i(com_valid), .x_com_i(x_com), .y_com_i(y_com),
        .err_count_o(chk_errors), .pending_o(pending));

    function automatic logic [12:0] cfg(logic [1:0] mode, logic [1:0] chan, logic [3:0] lo,
                                        logic [3:0] up, logic xh);
        return {mode, chan, lo, up, xh};
    endfunction

    // checker, testbench and assertion failures together
    function automatic int error_total();
        return chk_errors + tb_err + u_color_track_top.u_color_track_properties.fail_count;
    endfunction

    task automatic add_entry(int t, int h, int v, logic [15:0] p, logic fe, logic [12:0] s);
        e_test[n_entries] = t;
        e_h[n_entries]    = h;
        e_v[n_entries]    = v;
        e_pix[n_entries]  = p;
        e_last[n_entries] = fe;
        e_set[n_entries]  = s;
        e_idle[n_entries] = fe ? 45 : n_entries % 2;   // frame ends leave room for the divider
        n_entries++;
    endtask

    task automatic report_test(int t);
        int now;
        now = error_total();
        $display("test %0d %s: %s", t, test_name[t], (now == last_errs) ? "ok" : "failed");
        tests_run++;
        if (now != last_errs) tests_failed++;
        last_errs = now;
    endtask

    initial begin
        clk_pixel = 1'b0;
        forever #5 clk_pixel = ~clk_pixel;
    end

    initial begin : watchdog
        #1;
        repeat ((n_entries + 10) * 50) @(posedge clk_pixel);
        $display("timeout: run did not finish within %0d cycles", (n_entries + 10) * 50);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        recent_reset = 1'b1;
        pixel_valid  = 1'b0;
        frame_end    = 1'b0;
        hcount       = '0;
        vcount       = '0;
        pixel        = '0;
        settings     = '0;
        seed         = 32'hb2986eda;
        n_entries    = 0;
        tb_err       = 0;
        last_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 6; i++)
            add_entry(1, 10 + i, 5, 16'($random(seed)), i == 5,
                      cfg(MODE_CAMERA, CHAN_Y, 0, 15, 0));
        for (int c = 0; c < 4; c++)
            for (int i = 0; i < 4; i++)
                add_entry(2, 20 + i, 6 + c, 16'($random(seed)), i == 3,
                          cfg(MODE_CHANNEL, 2'(c), 0, 15, 0));
        // black has y = 16, sitting on a bound of 1, just outside 2 and 0
        for (int m = 2; m < 4; m++)
            for (int w = 0; w < 3; w++) begin
                logic [3:0] lo, up;
                lo = (w == 0) ? 4'd1 : (w == 1) ? 4'd2 : 4'd0;
                up = (w == 0) ? 4'd1 : (w == 1) ? 4'd15 : 4'd0;
                add_entry(3, 30, 7, 16'h0000, 0, cfg(2'(m), CHAN_Y, lo, up, 0));
                add_entry(3, 31, 7, 16'hFFFF, 0, cfg(2'(m), CHAN_Y, lo, up, 0));
                add_entry(3, 32, 7, 16'($random(seed)), 0, cfg(2'(m), CHAN_Y, lo, up, 0));
                add_entry(3, 33, 7, 16'h0000, 1, cfg(2'(m), CHAN_Y, lo, up, 0));
            end
        // masked at (100,50), (103,60), (200,70), centre lands on (134,60)
        add_entry(4, 100, 50, 16'h0000, 0, cfg(MODE_MASK, CHAN_Y, 1, 1, 0));
        add_entry(4, 300, 20, 16'hFFFF, 0, cfg(MODE_MASK, CHAN_Y, 1, 1, 0));
        add_entry(4, 103, 60, 16'h0000, 0, cfg(MODE_MASK, CHAN_Y, 1, 1, 0));
        add_entry(4, 200, 70, 16'h0000, 1, cfg(MODE_MASK, CHAN_Y, 1, 1, 0));
        add_entry(4, 10, 10, 16'hFFFF, 0, cfg(MODE_MASK, CHAN_Y, 1, 1, 0));  // empty frame
        add_entry(4, 11, 10, 16'hFFFF, 1, cfg(MODE_MASK, CHAN_Y, 1, 1, 0));
        for (int m = 0; m < 4; m++) begin
            add_entry(5, 134, 10, 16'($random(seed)), 0, cfg(2'(m), CHAN_Y, 0, 0, 1));
            add_entry(5, 5, 60, 16'($random(seed)), 0, cfg(2'(m), CHAN_Y, 0, 0, 1));
            add_entry(5, 134, 60, 16'($random(seed)), 0, cfg(2'(m), CHAN_Y, 0, 0, 1));
            add_entry(5, 7, 9, 16'($random(seed)), 1, cfg(2'(m), CHAN_Y, 0, 0, 1));
        end

        repeat (5) @(negedge clk_pixel);
        if (valid !== 1'b0 || com_valid !== 1'b0 || x_com !== '0 || y_com !== '0) begin
            $display("ERROR %0t: outputs not idle during reset", $time);
            tb_err++;
        end
        repeat (5) @(negedge clk_pixel);
        recent_reset = 1'b0;
        @(negedge clk_pixel);
        if (valid !== 1'b0 || com_valid !== 1'b0 || x_com !== '0 || y_com !== '0) begin
            $display("ERROR %0t: outputs not idle after reset", $time);
            tb_err++;
        end
        report_test(6);

        for (int i = 0; i < n_entries; i++) begin
            @(negedge clk_pixel);
            pixel_valid = 1'b1;
            frame_end   = e_last[i];
            hcount      = e_h[i];
            vcount      = e_v[i];
            pixel       = e_pix[i];
            settings    = e_set[i];
            if (e_idle[i] > 0) begin
                @(negedge clk_pixel);
                pixel_valid = 1'b0;
                frame_end = 1'b0;
                repeat (e_idle[i] - 1) @(negedge clk_pixel);
            end
            if (i == n_entries - 1 || e_test[i + 1] != e_test[i]) report_test(e_test[i]);
        end

        wait (pending == 0);   // watchdog bounds this
        $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_run - tests_failed, tests_failed, error_total());
        if (error_total() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* color_track_top.f */
src/color_track_pkg.sv
src/pixel_stream_if.sv
src/color_convert.sv
src/channel_threshold.sv
src/serial_divider.sv
src/center_of_mass.sv
src/video_mux.sv
src/color_track_top.sv
verification/color_track_checker.sv
verification/color_track_properties.sv
verification/color_track_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module color_track_tb -f color_track_top.f -o sim_color_track

out=$(./obj_dir/sim_color_track || true)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi
